// ==== all.f ====
verilog/mem_ctrl_pkg.sv
verilog/bus_rx_stage.sv
verilog/req_latch_stage.sv
verilog/mem_access_stage.sv
verilog/line_ram.sv
verilog/bus_return_stage.sv
verilog/mem_bus_ctrl_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// ==== Makefile ====
# Verilator build and run for the memory bus controller testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
SOURCES   := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail is taken from the log, not from the exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench top for the memory bus controller that drives directed and
// LFSR requests, withholds the grant at random and reports the results
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_top;

   localparam int          CLK_PERIOD  = 40;
   localparam int          DRIVE_DELAY = 1;
   localparam int          WAIT_LIMIT  = 600;
   localparam int          RANDOM_REQS = 200;
   localparam logic [15:0] LFSR_SEED   = 16'd34;

   logic                             bus_clk;
   logic                             rst;
   logic                             bus_req_valid;
   mem_ctrl_pkg::bus_req_t           bus_req;
   logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_data_in;
   logic                             bus_grant;
   logic                             ack_out;
   logic                             bus_br;
   logic                             resp_valid;
   logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_data_out;
   logic                             dest_ic;
   logic                             dest_dc;
   logic                             dest_dma;
   int                               pending;
   int                               errors;
   int                               checks;
   logic [15:0]                      stim_lfsr;
   logic [15:0]                      grant_lfsr;
   logic [31:0]                      grant_bits;
   logic [mem_ctrl_pkg::LINE_W-1:0]  data_line;
   logic                             timed_out;
   int                               grant_wait;
   int                               test_num;
   int                               err_mark;

   mem_bus_ctrl_top u_dut (
      .bus_clk       (bus_clk),
      .rst           (rst),
      .bus_req_valid (bus_req_valid),
      .bus_req       (bus_req),
      .bus_data_in   (bus_data_in),
      .bus_grant     (bus_grant),
      .ack_out       (ack_out),
      .bus_br        (bus_br),
      .resp_valid    (resp_valid),
      .bus_data_out  (bus_data_out),
      .dest_ic       (dest_ic),
      .dest_dc       (dest_dc),
      .dest_dma      (dest_dma)
   );

   tb_checker u_chk (
      .bus_clk       (bus_clk),
      .rst           (rst),
      .bus_req_valid (bus_req_valid),
      .bus_req       (bus_req),
      .bus_data_in   (bus_data_in),
      .ack_out       (ack_out),
      .bus_br        (bus_br),
      .resp_valid    (resp_valid),
      .bus_data_out  (bus_data_out),
      .dest_ic       (dest_ic),
      .dest_dc       (dest_dc),
      .dest_dma      (dest_dma),
      .pending       (pending),
      .errors        (errors),
      .checks        (checks)
   );

   initial
   begin
      bus_clk = 1'b0;
      forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
   end

   // Galois form with taps x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   task automatic take_bits(input int n, inout logic [15:0] st, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v  = {v[30:0], st[0]};
         st = lfsr_next(st);
      end
   endtask

   task automatic next_cycle();
      @(posedge bus_clk);
      #DRIVE_DELAY;
   endtask

   task automatic random_line(output logic [mem_ctrl_pkg::LINE_W-1:0] line);
      logic [31:0] v;
      for (int k = 0; k < mem_ctrl_pkg::BEATS_PER_LINE; k++)
      begin
         take_bits(32, stim_lfsr, v);
         line[k * 32 +: 32] = v;
      end
   endtask

   // Holds the request until ack_out and then sends the write beats
   task automatic send_req(input logic rw, input logic [15:0] addr, input logic [2:0] len,
                           input mem_ctrl_pkg::src_t src,
                           input logic [mem_ctrl_pkg::LINE_W-1:0] line);
      int waited;
      if (timed_out)
         return;
      bus_req.addr   = addr;
      bus_req.rw     = rw;
      bus_req.wr_len = len;
      bus_req.src    = src;
      bus_req_valid  = 1'b1;
      waited = 0;
      do
      begin
         next_cycle();
         waited++;
      end
      while (!ack_out && waited < WAIT_LIMIT);
      bus_req_valid = 1'b0;
      if (!ack_out)
      begin
         $display("Timeout: ack_out never came for address %h", addr);
         timed_out = 1'b1;
         return;
      end
      if (rw)
      begin
         for (int k = 0; k < mem_ctrl_pkg::BEATS_PER_LINE; k++)
         begin
            next_cycle();
            bus_data_in = line[k * 32 +: 32];
         end
      end
   endtask

   task automatic random_req();
      logic [31:0]                     v;
      logic                            rw;
      logic [15:0]                     addr;
      logic [2:0]                      len;
      mem_ctrl_pkg::src_t              src;
      logic [mem_ctrl_pkg::LINE_W-1:0] line;
      take_bits(1, stim_lfsr, v);
      rw = v[0];
      // Line index in bits 6..4 keeps traffic on 8 lines
      take_bits(7, stim_lfsr, v);
      addr = {9'b0, v[6:0]};
      take_bits(3, stim_lfsr, v);
      len = v[2:0];
      take_bits(2, stim_lfsr, v);
      src = (v[1:0] == 2'd0) ? mem_ctrl_pkg::SRC_IC :
            (v[1:0] == 2'd1) ? mem_ctrl_pkg::SRC_DC : mem_ctrl_pkg::SRC_DMA;
      line = '0;
      if (rw)
         random_line(line);
      send_req(rw, addr, len, src, line);
      take_bits(2, stim_lfsr, v);
      repeat (v) next_cycle();
   endtask

   // Drains outstanding reads and reports the test
   task automatic end_test(input string name);
      int waited;
      waited = 0;
      repeat (2) next_cycle();
      while (pending != 0 && waited < WAIT_LIMIT && !timed_out)
      begin
         next_cycle();
         waited++;
      end
      if (pending != 0 && !timed_out)
      begin
         $display("Timeout: %0d read responses never arrived", pending);
         timed_out = 1'b1;
      end
      test_num++;
      $display("Test %0d %-24s %s, %0d errors", test_num, name,
               (errors == err_mark && !timed_out) ? "ok" : "bad", errors - err_mark);
      err_mark = errors;
   endtask

   // Grant comes after a random number of cycles with bus_br high
   initial
   begin
      bus_grant  = 1'b0;
      grant_lfsr = LFSR_SEED;
      grant_wait = 0;
      forever
      begin
         next_cycle();
         if (bus_grant)
            bus_grant = 1'b0;
         else if (bus_br && !rst)
         begin
            if (grant_wait == 0)
            begin
               bus_grant = 1'b1;
               take_bits(6, grant_lfsr, grant_bits);
               grant_wait = int'(grant_bits);
            end
            else
               grant_wait--;
         end
      end
   end

   initial
   begin
      rst           = 1'b1;
      bus_req_valid = 1'b0;
      bus_req       = '0;
      bus_data_in   = '0;
      stim_lfsr     = LFSR_SEED;
      timed_out     = 1'b0;
      test_num      = 0;
      err_mark      = 0;
      repeat (2) @(posedge bus_clk);
      #DRIVE_DELAY;
      rst = 1'b0;

      repeat (8) next_cycle();
      end_test("idle after reset");

      send_req(1'b0, 16'h0050, 3'd0, mem_ctrl_pkg::SRC_IC, '0);
      send_req(1'b0, 16'h0070, 3'd0, mem_ctrl_pkg::SRC_DMA, '0);
      end_test("unwritten lines");

      random_line(data_line);
      send_req(1'b1, 16'h0015, 3'd2, mem_ctrl_pkg::SRC_DC, data_line);
      random_line(data_line);
      send_req(1'b1, 16'h001A, 3'd1, mem_ctrl_pkg::SRC_DC, data_line);
      send_req(1'b0, 16'h0010, 3'd0, mem_ctrl_pkg::SRC_DC, '0);
      end_test("write then read");

      // Full line at offset 12 runs past the line end
      random_line(data_line);
      send_req(1'b1, 16'h002C, 3'd4, mem_ctrl_pkg::SRC_DMA, data_line);
      send_req(1'b0, 16'h0020, 3'd0, mem_ctrl_pkg::SRC_DMA, '0);
      send_req(1'b0, 16'h0030, 3'd0, mem_ctrl_pkg::SRC_IC, '0);
      end_test("truncated write");

      send_req(1'b0, 16'h0010, 3'd0, mem_ctrl_pkg::SRC_IC, '0);
      send_req(1'b0, 16'h0020, 3'd0, mem_ctrl_pkg::SRC_DC, '0);
      send_req(1'b0, 16'h0010, 3'd0, mem_ctrl_pkg::SRC_DMA, '0);
      end_test("destination and order");

      for (int n = 0; n < RANDOM_REQS; n++)
         random_req();
      end_test("random with back-pressure");

      $display("Summary: %0d tests, %0d checks, %0d errors, %0s", test_num, checks, errors,
               timed_out ? "a wait timed out" : "no timeouts");
      if (errors == 0 && !timed_out)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== dv/tb_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Bus monitor for the controller testbench that keeps a line memory model
// in acknowledge order and compares every returned beat and destination
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_checker (
   input  logic                             bus_clk,
   input  logic                             rst,
   input  logic                             bus_req_valid,
   input  mem_ctrl_pkg::bus_req_t           bus_req,
   input  logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_data_in,
   input  logic                             ack_out,
   input  logic                             bus_br,
   input  logic                             resp_valid,
   input  logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_data_out,
   input  logic                             dest_ic,
   input  logic                             dest_dc,
   input  logic                             dest_dma,
   output int                               pending,
   output int                               errors,
   output int                               checks
);

   logic [mem_ctrl_pkg::LINE_W-1:0]  model_mem [mem_ctrl_pkg::RAM_LINES];
   logic [mem_ctrl_pkg::LINE_W-1:0]  exp_line_q [$];
   mem_ctrl_pkg::src_t               exp_src_q [$];
   mem_ctrl_pkg::bus_req_t           held_req;
   mem_ctrl_pkg::bus_req_t           wr_req;
   logic [mem_ctrl_pkg::LINE_W-1:0]  wr_line;
   logic [mem_ctrl_pkg::LINE_W-1:0]  cur_line;
   mem_ctrl_pkg::src_t               cur_src;
   int                               wr_beat;
   int                               rsp_beat;
   logic                             seen_req;

   // Length codes 0..4 double from one byte and the rest mean a full line
   function automatic int len_in_bytes(input mem_ctrl_pkg::wr_len_t code);
      case (code)
         3'd0:    return 1;
         3'd1:    return 2;
         3'd2:    return 4;
         3'd3:    return 8;
         default: return 16;
      endcase
   endfunction

   task automatic apply_write(input mem_ctrl_pkg::bus_req_t req,
                              input logic [mem_ctrl_pkg::LINE_W-1:0] line);
      int         off;
      logic [5:0] idx;
      off = int'(req.addr[3:0]);
      idx = req.addr[9:4];
      // Bytes that land past byte 15 are lost
      for (int b = 0; b < len_in_bytes(req.wr_len); b++)
      begin
         if (off + b < mem_ctrl_pkg::LINE_BYTES)
            model_mem[idx][(off + b) * 8 +: 8] = line[b * 8 +: 8];
      end
   endtask

   task automatic expect_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail %s: got %h, expected %h", name, got, exp);
      end
   endtask

   always @(negedge bus_clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < mem_ctrl_pkg::RAM_LINES; i++)
            model_mem[i] = '0;
         exp_line_q.delete();
         exp_src_q.delete();
         held_req = '0;
         wr_req   = '0;
         wr_line  = '0;
         cur_line = '0;
         cur_src  = '0;
         wr_beat  = -1;
         rsp_beat = 0;
         seen_req = 1'b0;
         pending  = 0;
         errors   = 0;
         checks   = 0;
      end
      else
      begin
         // Controller stays quiet until the first request
         if (!seen_req)
         begin
            expect_value("ack_out", 32'(ack_out), 32'd0);
            expect_value("bus_br", 32'(bus_br), 32'd0);
            expect_value("resp_valid", 32'(resp_valid), 32'd0);
         end
         if (bus_req_valid)
            seen_req = 1'b1;

         // Write beats follow the acknowledge low word first
         if (wr_beat >= 0)
         begin
            wr_line[wr_beat * 32 +: 32] = bus_data_in;
            wr_beat++;
            if (wr_beat == mem_ctrl_pkg::BEATS_PER_LINE)
            begin
               apply_write(wr_req, wr_line);
               wr_beat = -1;
            end
         end

         if (ack_out)
         begin
            if (held_req.rw)
            begin
               wr_req  = held_req;
               wr_beat = 0;
            end
            else
            begin
               exp_line_q.push_back(model_mem[held_req.addr[9:4]]);
               exp_src_q.push_back(held_req.src);
               pending++;
               if (pending > 2)
               begin
                  errors++;
                  $display("More than two reads were acknowledged ahead of a pending response");
               end
            end
         end

         // The master may already present its next request in the acknowledge cycle
         if (bus_req_valid)
            held_req = bus_req;

         if (resp_valid)
         begin
            if (rsp_beat == 0)
            begin
               if (exp_line_q.size() == 0)
               begin
                  errors++;
                  $display("A response arrived while no read was outstanding");
                  cur_line = '0;
                  cur_src  = '0;
               end
               else
               begin
                  cur_line = exp_line_q.pop_front();
                  cur_src  = exp_src_q.pop_front();
               end
            end
            expect_value($sformatf("bus_data_out beat %0d", rsp_beat), bus_data_out,
                         cur_line[rsp_beat * 32 +: 32]);
            expect_value("dest_dma dest_dc dest_ic", 32'({dest_dma, dest_dc, dest_ic}),
                         32'(cur_src));
            rsp_beat++;
            if (rsp_beat == mem_ctrl_pkg::BEATS_PER_LINE)
            begin
               rsp_beat = 0;
               pending--;
            end
         end
      end
   end

endmodule

// ==== verilog/mem_bus_ctrl_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory-side bus controller with its line memory behind the bus ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_bus_ctrl_top (
   input  logic                             bus_clk,
   input  logic                             rst,
   input  logic                             bus_req_valid,
   input  mem_ctrl_pkg::bus_req_t           bus_req,
   input  logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_data_in,
   input  logic                             bus_grant,
   output logic                             ack_out,
   output logic                             bus_br,
   output logic                             resp_valid,
   output logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_data_out,
   output logic                             dest_ic,
   output logic                             dest_dc,
   output logic                             dest_dma
);

   logic                                 rx_load;
   mem_ctrl_pkg::mem_req_t               rx_req;
   logic                                 wr_slot_full;
   logic                                 rd_slot_valid;
   mem_ctrl_pkg::mem_req_t               rd_slot;
   logic                                 slot_done;
   logic                                 wr_done;
   logic                                 rd_done;
   logic                                 ram_en;
   logic                                 ram_we;
   logic [mem_ctrl_pkg::LINE_IDX_W-1:0]  ram_idx;
   logic [mem_ctrl_pkg::LINE_BYTES-1:0]  ram_be;
   logic [mem_ctrl_pkg::LINE_W-1:0]      ram_wdata;
   logic [mem_ctrl_pkg::LINE_W-1:0]      ram_rdata;
   logic                                 line_ready;
   logic [mem_ctrl_pkg::LINE_W-1:0]      line_data;

   // Read slot frees on a finished write or a finished response
   assign slot_done = wr_done | rd_done;

   bus_rx_stage u_rx (
      .bus_clk       (bus_clk),
      .rst           (rst),
      .bus_req_valid (bus_req_valid),
      .bus_req       (bus_req),
      .bus_data_in   (bus_data_in),
      .wr_slot_full  (wr_slot_full),
      .ack_out       (ack_out),
      .rx_load       (rx_load),
      .rx_req        (rx_req)
   );

   req_latch_stage u_latch (
      .bus_clk       (bus_clk),
      .rst           (rst),
      .rx_load       (rx_load),
      .rx_req        (rx_req),
      .slot_done     (slot_done),
      .wr_slot_full  (wr_slot_full),
      .rd_slot_valid (rd_slot_valid),
      .rd_slot       (rd_slot)
   );

   mem_access_stage u_access (
      .bus_clk       (bus_clk),
      .rst           (rst),
      .rd_slot_valid (rd_slot_valid),
      .rd_slot       (rd_slot),
      .slot_done     (slot_done),
      .ram_rdata     (ram_rdata),
      .ram_en        (ram_en),
      .ram_we        (ram_we),
      .ram_idx       (ram_idx),
      .ram_be        (ram_be),
      .ram_wdata     (ram_wdata),
      .line_ready    (line_ready),
      .line_data     (line_data),
      .wr_done       (wr_done)
   );

   line_ram u_ram (
      .bus_clk   (bus_clk),
      .rst       (rst),
      .ram_en    (ram_en),
      .ram_we    (ram_we),
      .ram_idx   (ram_idx),
      .ram_be    (ram_be),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata)
   );

   bus_return_stage u_return (
      .bus_clk      (bus_clk),
      .rst          (rst),
      .line_ready   (line_ready),
      .line_data    (line_data),
      .rd_slot      (rd_slot),
      .bus_grant    (bus_grant),
      .bus_br       (bus_br),
      .resp_valid   (resp_valid),
      .bus_data_out (bus_data_out),
      .dest_ic      (dest_ic),
      .dest_dc      (dest_dc),
      .dest_dma     (dest_dma),
      .rd_done      (rd_done)
   );

endmodule

// ==== verilog/bus_return_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Read return stage that requests the bus, waits for the grant and sends
// the line in beats
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bus_return_stage (
   input  logic                             bus_clk,
   input  logic                             rst,
   input  logic                             line_ready,
   input  logic [mem_ctrl_pkg::LINE_W-1:0]  line_data,
   input  mem_ctrl_pkg::mem_req_t           rd_slot,
   input  logic                             bus_grant,
   output logic                             bus_br,
   output logic                             resp_valid,
   output logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_data_out,
   output logic                             dest_ic,
   output logic                             dest_dc,
   output logic                             dest_dma,
   output logic                             rd_done
);

   typedef enum logic [1:0] {
      RT_IDLE,
      RT_REQ,
      RT_SEND
   } rt_state_t;

   rt_state_t                            state;
   logic [mem_ctrl_pkg::BEAT_CNT_W-1:0]  beat_cnt;
   logic [mem_ctrl_pkg::LINE_W-1:0]      line_q;
   logic                                 last_beat;

   assign last_beat = (beat_cnt == mem_ctrl_pkg::BEAT_CNT_W'(mem_ctrl_pkg::BEATS_PER_LINE - 1));

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         state    <= RT_IDLE;
         beat_cnt <= '0;
      end
      else
      begin
         case (state)
            RT_IDLE:
               if (line_ready)
                  state <= RT_REQ;
            RT_REQ:
               if (bus_grant)
               begin
                  state    <= RT_SEND;
                  beat_cnt <= '0;
               end
            RT_SEND:
            begin
               beat_cnt <= beat_cnt + 1'b1;
               if (last_beat)
                  state <= RT_IDLE;
            end
            default:
               state <= RT_IDLE;
         endcase
      end
   end

   // Line shifts down one beat per send cycle so the low word goes first
   always_ff @(posedge bus_clk)
   begin
      if (line_ready)
         line_q <= line_data;
      else if (state == RT_SEND)
         line_q <= line_q >> mem_ctrl_pkg::BEAT_W;
   end

   assign bus_br       = (state == RT_REQ);
   assign resp_valid   = (state == RT_SEND);
   assign bus_data_out = line_q[mem_ctrl_pkg::BEAT_W-1:0];
   assign rd_done      = resp_valid && last_beat;

   // Destination follows the source of the read in the slot
   assign dest_ic  = resp_valid && |(rd_slot.req.src & mem_ctrl_pkg::SRC_IC);
   assign dest_dc  = resp_valid && |(rd_slot.req.src & mem_ctrl_pkg::SRC_DC);
   assign dest_dma = resp_valid && |(rd_slot.req.src & mem_ctrl_pkg::SRC_DMA);

endmodule

// ==== verilog/line_ram.sv ====
////////////////////////////////////////////////////////////////////////////
// Line memory under the controller with byte-enabled writes and
// registered reads
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module line_ram (
   input  logic                                 bus_clk,
   input  logic                                 rst,
   input  logic                                 ram_en,
   input  logic                                 ram_we,
   input  logic [mem_ctrl_pkg::LINE_IDX_W-1:0]  ram_idx,
   input  logic [mem_ctrl_pkg::LINE_BYTES-1:0]  ram_be,
   input  logic [mem_ctrl_pkg::LINE_W-1:0]      ram_wdata,
   output logic [mem_ctrl_pkg::LINE_W-1:0]      ram_rdata
);

   logic [mem_ctrl_pkg::LINE_W-1:0] mem_array [mem_ctrl_pkg::RAM_LINES];

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < mem_ctrl_pkg::RAM_LINES; i++)
            mem_array[i] <= '0;
         ram_rdata <= '0;
      end
      else if (ram_en)
      begin
         if (ram_we)
         begin
            for (int b = 0; b < mem_ctrl_pkg::LINE_BYTES; b++)
               if (ram_be[b])
                  mem_array[ram_idx][b*8 +: 8] <= ram_wdata[b*8 +: 8];
         end
         else
            ram_rdata <= mem_array[ram_idx];
      end
   end

endmodule

// ==== verilog/mem_access_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Memory access stage with a fixed delay timer, write alignment and byte
// enables toward the line memory
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mem_access_stage (
   input  logic                                 bus_clk,
   input  logic                                 rst,
   input  logic                                 rd_slot_valid,
   input  mem_ctrl_pkg::mem_req_t               rd_slot,
   input  logic                                 slot_done,
   input  logic [mem_ctrl_pkg::LINE_W-1:0]      ram_rdata,
   output logic                                 ram_en,
   output logic                                 ram_we,
   output logic [mem_ctrl_pkg::LINE_IDX_W-1:0]  ram_idx,
   output logic [mem_ctrl_pkg::LINE_BYTES-1:0]  ram_be,
   output logic [mem_ctrl_pkg::LINE_W-1:0]      ram_wdata,
   output logic                                 line_ready,
   output logic [mem_ctrl_pkg::LINE_W-1:0]      line_data,
   output logic                                 wr_done
);

   localparam int TIMER_W = mem_ctrl_pkg::MEM_DELAY + 2;
   localparam int BE_W    = 2 * mem_ctrl_pkg::LINE_BYTES;

   logic [TIMER_W-1:0]                 mem_timer;
   logic [mem_ctrl_pkg::OFFSET_W-1:0]  offset;
   logic [5:0]                         len_bytes;
   logic [BE_W-1:0]                    be_wide;
   logic                               access_cyc;
   logic                               result_cyc;

   ////////////////////////////////////////////////////////////////////////////
   // Timer gains one set bit per cycle after the slot arrives
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge bus_clk)
   begin
      if (rst)
         mem_timer <= '0;
      else if (!rd_slot_valid || slot_done)
         mem_timer <= '0;
      else
         mem_timer <= {mem_timer[TIMER_W-2:0], 1'b1};
   end

   // Edges of the thermometer give single-cycle strobes
   assign access_cyc = rd_slot_valid && mem_timer[mem_ctrl_pkg::MEM_DELAY-1]
                       && !mem_timer[mem_ctrl_pkg::MEM_DELAY];
   assign result_cyc = rd_slot_valid && mem_timer[mem_ctrl_pkg::MEM_DELAY]
                       && !mem_timer[mem_ctrl_pkg::MEM_DELAY+1];

   ////////////////////////////////////////////////////////////////////////////
   // Write alignment
   ////////////////////////////////////////////////////////////////////////////
   assign offset = rd_slot.req.addr[mem_ctrl_pkg::OFFSET_W-1:0];

   always_comb
   begin
      case (rd_slot.req.wr_len)
         3'd0:    len_bytes = 6'd1;
         3'd1:    len_bytes = 6'd2;
         3'd2:    len_bytes = 6'd4;
         3'd3:    len_bytes = 6'd8;
         default: len_bytes = 6'd16;
      endcase
      be_wide = (BE_W'(1) << len_bytes) - 1'b1;
      // Bits past byte 15 are cut off at the line end
      be_wide = be_wide << offset;
   end

   assign ram_be    = be_wide[mem_ctrl_pkg::LINE_BYTES-1:0];
   assign ram_wdata = rd_slot.data << {offset, 3'b000};
   assign ram_idx   = rd_slot.req.addr[mem_ctrl_pkg::OFFSET_W +: mem_ctrl_pkg::LINE_IDX_W];

   assign ram_en     = access_cyc;
   assign ram_we     = access_cyc && rd_slot.req.rw;
   assign wr_done    = result_cyc && rd_slot.req.rw;
   assign line_ready = result_cyc && !rd_slot.req.rw;
   assign line_data  = ram_rdata;

endmodule

// ==== verilog/req_latch_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Write slot and read slot holding up to two accepted requests in order
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module req_latch_stage (
   input  logic                   bus_clk,
   input  logic                   rst,
   input  logic                   rx_load,
   input  mem_ctrl_pkg::mem_req_t rx_req,
   input  logic                   slot_done,
   output logic                   wr_slot_full,
   output logic                   rd_slot_valid,
   output mem_ctrl_pkg::mem_req_t rd_slot
);

   mem_ctrl_pkg::mem_req_t wr_slot;
   logic                   wr_valid;
   logic                   rd_valid;
   logic                   advance;

   // Read slot empty or being freed this cycle
   assign advance = wr_valid && (!rd_valid || slot_done);

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         wr_valid <= 1'b0;
         rd_valid <= 1'b0;
      end
      else
      begin
         if (rx_load)
            wr_valid <= 1'b1;
         else if (advance)
            wr_valid <= 1'b0;

         if (advance)
            rd_valid <= 1'b1;
         else if (slot_done)
            rd_valid <= 1'b0;
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (rx_load)
         wr_slot <= rx_req;
      if (advance)
         rd_slot <= wr_slot;
   end

   assign wr_slot_full  = wr_valid;
   assign rd_slot_valid = rd_valid;

endmodule

// ==== verilog/bus_rx_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Bus receive stage that acknowledges a master and collects write beats
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module bus_rx_stage (
   input  logic                             bus_clk,
   input  logic                             rst,
   input  logic                             bus_req_valid,
   input  mem_ctrl_pkg::bus_req_t           bus_req,
   input  logic [mem_ctrl_pkg::BEAT_W-1:0]  bus_data_in,
   input  logic                             wr_slot_full,
   output logic                             ack_out,
   output logic                             rx_load,
   output mem_ctrl_pkg::mem_req_t           rx_req
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_ACK,
      RX_DATA,
      RX_LOAD
   } rx_state_t;

   rx_state_t                               state;
   logic [mem_ctrl_pkg::BEAT_CNT_W-1:0]     beat_cnt;
   logic                                    accept;
   mem_ctrl_pkg::bus_req_t                  req_q;
   logic [mem_ctrl_pkg::LINE_W-1:0]         line_q;

   // Take a new request only when the write slot has room
   assign accept = (state == RX_IDLE) && bus_req_valid && !wr_slot_full;

   always_ff @(posedge bus_clk)
   begin
      if (rst)
      begin
         state    <= RX_IDLE;
         beat_cnt <= '0;
      end
      else
      begin
         case (state)
            RX_IDLE:
               if (accept)
                  state <= RX_ACK;
            RX_ACK:
            begin
               beat_cnt <= '0;
               // Reads carry no data beats
               state    <= req_q.rw ? RX_DATA : RX_LOAD;
            end
            RX_DATA:
            begin
               beat_cnt <= beat_cnt + 1'b1;
               if (beat_cnt == mem_ctrl_pkg::BEAT_CNT_W'(mem_ctrl_pkg::BEATS_PER_LINE - 1))
                  state <= RX_LOAD;
            end
            default:
               state <= RX_IDLE;
         endcase
      end
   end

   // Request fields and the write line
   always_ff @(posedge bus_clk)
   begin
      if (accept)
         req_q <= bus_req;
      if (state == RX_DATA)
         line_q[beat_cnt*mem_ctrl_pkg::BEAT_W +: mem_ctrl_pkg::BEAT_W] <= bus_data_in;
   end

   assign ack_out     = (state == RX_ACK);
   assign rx_load     = (state == RX_LOAD);
   assign rx_req.req  = req_q;
   assign rx_req.data = line_q;

endmodule

// ==== verilog/mem_ctrl_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Widths, requester codes and request structs shared by every stage
// of the memory-side bus controller
////////////////////////////////////////////////////////////////////////////
package mem_ctrl_pkg;

   // Bus and line geometry
   localparam int BEAT_W         = 32;
   localparam int LINE_W         = 128;
   localparam int LINE_BYTES     = 16;
   localparam int BEATS_PER_LINE = 4;
   localparam int BEAT_CNT_W     = 2;

   // Byte offset in bits 3..0 and line index above it
   localparam int ADDR_W     = 16;
   localparam int OFFSET_W   = 4;
   localparam int RAM_LINES  = 64;
   localparam int LINE_IDX_W = 6;

   // Cycles from the read slot filling to the memory enable
   localparam int MEM_DELAY = 3;

   // One-hot requester code
   typedef logic [2:0] src_t;
   localparam src_t SRC_IC  = 3'b001;
   localparam src_t SRC_DC  = 3'b010;
   localparam src_t SRC_DMA = 3'b100;

   // 0..4 select 1, 2, 4, 8, 16 bytes; larger codes act as 16
   typedef logic [2:0] wr_len_t;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              rw;
      wr_len_t           wr_len;
      src_t              src;
   } bus_req_t;

   // Write beats sit low word first in data
   typedef struct packed {
      bus_req_t          req;
      logic [LINE_W-1:0] data;
   } mem_req_t;

endpackage
